/* rtl/mul_pkg.sv */
package mul_pkg;

    // ==============================
    // widths
    // ==============================

    // operand and result half
    localparam int xlen   = 64;

    // operand after sign/zero extension
    localparam int ext_w  = xlen + 2;

    // partial product row and full product
    localparam int prod_w = 2 * ext_w;

    // word mode (mulw) operand width
    localparam int word_w = 32;

    // radix-4 booth, one row per two multiplier bits
    localparam int pp_rows   = ext_w / 2;

    // booth rows plus the negation-bit row
    localparam int tree_rows = pp_rows + 1;

    // ==============================
    // types
    // ==============================

    typedef logic [xlen-1:0]   operand_t;
    typedef logic [prod_w-1:0] row_t;

    typedef struct packed {
        logic     mulw;
        logic     sign_a;
        logic     sign_b;
        operand_t a;
        operand_t b;
    } mul_req_t;

    // registered booth output, row tree_rows-1 holds the negation bits
    typedef row_t [tree_rows-1:0] pp_bank_t;

    // carry-save form of the product
    typedef struct packed {
        row_t sum;
        row_t carry;
    } csa_pair_t;

    typedef struct packed {
        operand_t hi;
        operand_t lo;
    } mul_resp_t;

endpackage

/* rtl/booth_stage.sv */
`timescale 1ns/1ps

module booth_stage (
    input  logic               clk,
    input  logic               rst,
    input  logic               accept,
    input  mul_pkg::mul_req_t  req,
    output mul_pkg::pp_bank_t  pp,
    output logic               pp_valid,
    output logic               pp_mulw
);

    import mul_pkg::*;

    // ==============================
    // operand extension
    // ==============================

    // word mode keeps only the low word, then extends per sign flag
    function automatic logic [ext_w-1:0] extend_op(
        input operand_t v,
        input logic     sgn,
        input logic     word
    );
        logic msb;
        if (word) begin
            msb = sgn & v[word_w-1];
            return {{(ext_w-word_w){msb}}, v[word_w-1:0]};
        end
        msb = sgn & v[xlen-1];
        return {{(ext_w-xlen){msb}}, v};
    endfunction

    logic [ext_w-1:0] a_ext;
    logic [ext_w-1:0] b_ext;
    logic [ext_w:0]   b_pad;

    assign a_ext = extend_op(req.a, req.sign_a, req.mulw);
    assign b_ext = extend_op(req.b, req.sign_b, req.mulw);

    // implicit zero below bit 0 for the first booth group
    assign b_pad = {b_ext, 1'b0};

    // A and 2A sign-extended to full row width
    row_t a_row;
    row_t a2_row;

    assign a_row  = {{ext_w{a_ext[ext_w-1]}}, a_ext};
    assign a2_row = {{(ext_w-1){a_ext[ext_w-1]}}, a_ext, 1'b0};

    // ==============================
    // booth rows
    // ==============================

    logic [pp_rows-1:0] neg;
    row_t               pp_row [pp_rows];

    for (genvar i = 0; i < pp_rows; i++) begin : g_row
        logic [2:0] grp;
        logic       one;
        logic       two;
        row_t       mag;

        assign grp    = b_pad[2*i+2 -: 3];
        // 100, 101, 110 select a negative multiple, 111 is zero
        assign neg[i] = grp[2] & ~(grp[1] & grp[0]);
        assign one    = grp[1] ^ grp[0];
        assign two    = (grp == 3'b011) | (grp == 3'b100);
        assign mag    = ({prod_w{one}} & a_row) | ({prod_w{two}} & a2_row);

        // one's complement here, the +1 lands in the negation row
        assign pp_row[i] = (neg[i] ? ~mag : mag) << (2 * i);
    end

    pp_bank_t pp_next;

    always_comb begin
        pp_next = '0;
        for (int k = 0; k < pp_rows; k++) begin
            pp_next[k] = pp_row[k];
            pp_next[tree_rows-1][2*k] = neg[k];
        end
    end

    // ==============================
    // stage register
    // ==============================

    always_ff @(posedge clk) begin
        if (rst) begin
            pp_valid <= 1'b0;
        end else begin
            pp_valid <= accept;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            pp      <= pp_next;
            pp_mulw <= req.mulw;
        end
    end

endmodule

/* rtl/csa_stage.sv */
`timescale 1ns/1ps

module csa_stage (
    input  logic                clk,
    input  logic                rst,
    input  mul_pkg::pp_bank_t   pp,
    input  logic                pp_valid,
    input  logic                pp_mulw,
    output mul_pkg::csa_pair_t  pair,
    output logic                pair_valid,
    output logic                pair_mulw
);

    import mul_pkg::*;

    // ==============================
    // tree shape
    // ==============================

    // rows left after a given number of 3:2 layers
    function automatic int csa_rows(input int layer);
        int n;
        n = tree_rows;
        for (int k = 0; k < layer; k++) begin
            n = 2 * (n / 3) + n % 3;
        end
        return n;
    endfunction

    // layers needed to get down to two rows
    function automatic int csa_depth();
        int d;
        d = 0;
        while (csa_rows(d) > 2) begin
            d++;
        end
        return d;
    endfunction

    // lvl[l] holds the rows entering layer l, unused slots tied low
    row_t lvl [csa_depth()+1][tree_rows];

    for (genvar r = 0; r < tree_rows; r++) begin : g_in
        assign lvl[0][r] = pp[r];
    end

    // ==============================
    // wallace layers
    // ==============================

    for (genvar l = 0; l < csa_depth(); l++) begin : g_layer
        localparam int n_in  = csa_rows(l);
        localparam int n_grp = n_in / 3;

        for (genvar g = 0; g < n_grp; g++) begin : g_csa
            row_t x;
            row_t y;
            row_t z;

            assign x = lvl[l][3*g];
            assign y = lvl[l][3*g+1];
            assign z = lvl[l][3*g+2];

            assign lvl[l+1][2*g]   = x ^ y ^ z;
            // carry weight is one place up, top bit drops out mod 2^prod_w
            assign lvl[l+1][2*g+1] = ((x & y) | (x & z) | (y & z)) << 1;
        end

        // rows that do not fill a group of three
        for (genvar r = 0; r < n_in % 3; r++) begin : g_pass
            assign lvl[l+1][2*n_grp+r] = lvl[l][3*n_grp+r];
        end

        for (genvar r = csa_rows(l+1); r < tree_rows; r++) begin : g_pad
            assign lvl[l+1][r] = '0;
        end
    end

    // ==============================
    // stage register
    // ==============================

    always_ff @(posedge clk) begin
        if (rst) begin
            pair_valid <= 1'b0;
        end else begin
            pair_valid <= pp_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (pp_valid) begin
            pair.sum   <= lvl[csa_depth()][0];
            pair.carry <= lvl[csa_depth()][1];
            pair_mulw  <= pp_mulw;
        end
    end

endmodule

/* rtl/mul_top.sv */
`timescale 1ns/1ps

module mul_top (
    input  logic                clk,
    input  logic                rst,
    input  logic                mul_valid,
    input  mul_pkg::mul_req_t   req,
    output logic                mul_ready,
    output logic                mul_out_valid,
    output mul_pkg::mul_resp_t  resp
);

    import mul_pkg::*;

    logic      accept;
    pp_bank_t  pp;
    logic      pp_valid;
    logic      pp_mulw;
    csa_pair_t pair;
    logic      pair_valid;
    logic      pair_mulw;
    row_t      product;

    // ==============================
    // handshake
    // ==============================

    // single issue, busy while anything is in either stage
    assign mul_ready     = ~(pp_valid | pair_valid);
    assign accept        = mul_valid & mul_ready;
    assign mul_out_valid = pair_valid;

    // ==============================
    // pipeline
    // ==============================

    booth_stage i_booth (
        .clk      (clk),
        .rst      (rst),
        .accept   (accept),
        .req      (req),
        .pp       (pp),
        .pp_valid (pp_valid),
        .pp_mulw  (pp_mulw)
    );

    csa_stage i_csa (
        .clk        (clk),
        .rst        (rst),
        .pp         (pp),
        .pp_valid   (pp_valid),
        .pp_mulw    (pp_mulw),
        .pair       (pair),
        .pair_valid (pair_valid),
        .pair_mulw  (pair_mulw)
    );

    // final carry-propagate add
    assign product = pair.sum + pair.carry;

    assign resp.hi = product[2*xlen-1:xlen];
    // mulw returns the low word sign-extended
    assign resp.lo = pair_mulw ? {{(xlen-word_w){product[word_w-1]}}, product[word_w-1:0]}
                               : product[xlen-1:0];

endmodule

/* verif/mul_props.sv */
`timescale 1ns/1ps

module mul_props (
    input logic clk,
    input logic rst,
    input logic mul_valid,
    input logic mul_ready,
    input logic mul_out_valid
);

    logic accept;

    assign accept = mul_valid & mul_ready;

    // ==============================
    // handshake timing
    // ==============================

    // result two edges after the accepting edge
    a_accept_result: assert property (
        @(posedge clk) disable iff (rst)
        accept |-> ##2 mul_out_valid
    ) else $error("accepted request gave no result two cycles later");

    a_result_one_cycle: assert property (
        @(posedge clk) disable iff (rst)
        mul_out_valid |=> !mul_out_valid
    ) else $error("mul_out_valid stayed high for two cycles");

    // busy while the result is presented and free right after
    a_busy_on_result: assert property (
        @(posedge clk) disable iff (rst)
        mul_out_valid |-> !mul_ready ##1 mul_ready
    ) else $error("mul_ready not low with the result or not high right after it");

endmodule

bind mul_top mul_props i_mul_props (
    .clk           (clk),
    .rst           (rst),
    .mul_valid     (mul_valid),
    .mul_ready     (mul_ready),
    .mul_out_valid (mul_out_valid)
);

/* verif/tb_mul.sv */
`timescale 1ns/1ps

module tb_mul;

    import mul_pkg::*;

    localparam int half_period    = 20;
    localparam int drive_delay    = 2;
    localparam int reset_cycles   = 10;
    localparam int timeout_cycles = 20;
    localparam int rand_ops       = 50;
    localparam int word_ops       = 25;

    logic      clk;
    logic      rst;
    logic      mul_valid;
    mul_req_t  req;
    logic      mul_ready;
    logic      mul_out_valid;
    mul_resp_t resp;

    int        errors;
    int        timeouts;
    integer    seed;
    operand_t  corners [5];

    mul_top i_mul_top (
        .clk           (clk),
        .rst           (rst),
        .mul_valid     (mul_valid),
        .req           (req),
        .mul_ready     (mul_ready),
        .mul_out_valid (mul_out_valid),
        .resp          (resp)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(half_period) clk = ~clk;
        end
    end

    // ==============================
    // reference model
    // ==============================

    // value of the low w bits, two's complement when sgn is set
    function automatic logic signed [prod_w-1:0] operand_value(
        input operand_t v,
        input logic     sgn,
        input int       w
    );
        logic signed [prod_w-1:0] val;
        logic signed [prod_w-1:0] span;
        val  = '0;
        span = '0;
        for (int i = 0; i < w; i++) begin
            val[i] = v[i];
        end
        span[w] = 1'b1;
        if (sgn && v[w-1]) begin
            val = val - span;
        end
        return val;
    endfunction

    function automatic mul_resp_t model_mul(input mul_req_t r);
        logic signed [prod_w-1:0] a_val;
        logic signed [prod_w-1:0] b_val;
        logic signed [prod_w-1:0] p;
        mul_resp_t                m;
        int                       w;
        w     = r.mulw ? word_w : xlen;
        a_val = operand_value(r.a, r.sign_a, w);
        b_val = operand_value(r.b, r.sign_b, w);
        p     = a_val * b_val;
        m.hi  = p[2*xlen-1:xlen];
        m.lo  = p[xlen-1:0];
        if (r.mulw) begin
            m.lo = {{(xlen-word_w){p[word_w-1]}}, p[word_w-1:0]};
        end
        return m;
    endfunction

    function automatic mul_req_t random_req(
        input logic mulw,
        input logic sign_a,
        input logic sign_b
    );
        mul_req_t r;
        r.mulw   = mulw;
        r.sign_a = sign_a;
        r.sign_b = sign_b;
        r.a      = {$random(seed), $random(seed)};
        r.b      = {$random(seed), $random(seed)};
        return r;
    endfunction

    // ==============================
    // compare tasks
    // ==============================

    task automatic check_resp(input string name, input mul_resp_t exp, input mul_resp_t act);
        if (act.hi !== exp.hi) begin
            $display("Error %s: hi expected %h actual %h", name, exp.hi, act.hi);
            errors++;
        end
        if (act.lo !== exp.lo) begin
            $display("Error %s: lo expected %h actual %h", name, exp.lo, act.lo);
            errors++;
        end
    endtask

    task automatic check_bit(input string name, input string field, input logic exp,
                             input logic act);
        if (act !== exp) begin
            $display("Error %s: %s expected %b actual %b", name, field, exp, act);
            errors++;
        end
    endtask

    // ==============================
    // bounded waits
    // ==============================

    task automatic wait_ready(input string name);
        int n;
        n = 0;
        while (mul_ready !== 1'b1 && n < timeout_cycles) begin
            @(posedge clk);
            #(drive_delay);
            n++;
        end
        if (mul_ready !== 1'b1) begin
            $display("Timeout in %s: mul_ready stayed low for %0d cycles", name, n);
            timeouts++;
        end
    endtask

    task automatic wait_out_valid(input string name);
        int n;
        n = 0;
        while (mul_out_valid !== 1'b1 && n < timeout_cycles) begin
            @(posedge clk);
            #(drive_delay);
            n++;
        end
        if (mul_out_valid !== 1'b1) begin
            $display("Timeout in %s: no result within %0d cycles", name, n);
            timeouts++;
        end
    endtask

    // ==============================
    // transactions
    // ==============================

    task automatic run_op(input string name, input mul_req_t r, input mul_resp_t exp);
        wait_ready(name);
        mul_valid = 1'b1;
        req       = r;
        @(posedge clk);
        #(drive_delay);
        mul_valid = 1'b0;
        // request is only sampled on the accept edge
        req       = random_req(1'b0, 1'b0, 1'b0);
        wait_out_valid(name);
        if (mul_out_valid === 1'b1) begin
            check_resp(name, exp, resp);
            check_bit(name, "mul_ready", 1'b0, mul_ready);
        end
    endtask

    // valid held high through the busy window, one result expected
    task automatic check_timing(input string name);
        mul_req_t  r;
        mul_resp_t exp;
        int        extra;
        r   = random_req(1'b0, 1'b1, 1'b1);
        exp = model_mul(r);
        wait_ready(name);
        mul_valid = 1'b1;
        req       = r;
        @(posedge clk);
        #(drive_delay);
        check_bit(name, "mul_ready", 1'b0, mul_ready);
        check_bit(name, "mul_out_valid", 1'b0, mul_out_valid);
        req = random_req(1'b0, 1'b0, 1'b1);
        @(posedge clk);
        #(drive_delay);
        check_bit(name, "mul_ready", 1'b0, mul_ready);
        check_bit(name, "mul_out_valid", 1'b1, mul_out_valid);
        check_resp(name, exp, resp);
        @(posedge clk);
        #(drive_delay);
        check_bit(name, "mul_ready", 1'b1, mul_ready);
        check_bit(name, "mul_out_valid", 1'b0, mul_out_valid);
        mul_valid = 1'b0;
        extra     = 0;
        for (int i = 0; i < 6; i++) begin
            @(posedge clk);
            #(drive_delay);
            if (mul_out_valid === 1'b1) begin
                extra++;
            end
        end
        if (extra != 0) begin
            $display("Error %s: extra results expected 0 actual %0d", name, extra);
            errors++;
        end
    endtask

    // ==============================
    // main sequence
    // ==============================

    initial begin
        mul_req_t  r;
        mul_req_t  r2;
        mul_resp_t exp;
        errors    = 0;
        timeouts  = 0;
        seed      = 32'h2f683930;
        rst       = 1'b1;
        mul_valid = 1'b0;
        req       = '0;

        corners[0] = 64'h0000_0000_0000_0000;
        corners[1] = 64'h0000_0000_0000_0001;
        corners[2] = 64'hffff_ffff_ffff_ffff;
        corners[3] = 64'h8000_0000_0000_0000;
        corners[4] = 64'h0000_0000_8000_0000;

        repeat (reset_cycles) @(posedge clk);
        #(drive_delay);
        rst = 1'b0;
        check_bit("reset", "mul_ready", 1'b1, mul_ready);
        check_bit("reset", "mul_out_valid", 1'b0, mul_out_valid);

        // s[1] is sign_a, s[0] is sign_b
        for (int s = 0; s < 4; s++) begin
            for (int i = 0; i < rand_ops; i++) begin
                r = random_req(1'b0, s[1], s[0]);
                run_op($sformatf("rand_s%0d_%0d", s, i), r, model_mul(r));
            end
        end

        // upper operand halves changed, same expected result
        for (int s = 0; s < 4; s++) begin
            for (int i = 0; i < word_ops; i++) begin
                r   = random_req(1'b1, s[1], s[0]);
                exp = model_mul(r);
                r2  = r;
                r2.a[xlen-1:word_w] = $random(seed);
                r2.b[xlen-1:word_w] = $random(seed);
                run_op($sformatf("word_s%0d_%0d", s, i), r, exp);
                run_op($sformatf("word_hi_s%0d_%0d", s, i), r2, exp);
            end
        end

        for (int i = 0; i < 5; i++) begin
            for (int j = 0; j < 5; j++) begin
                for (int s = 0; s < 4; s++) begin
                    for (int w = 0; w < 2; w++) begin
                        r.mulw   = w[0];
                        r.sign_a = s[1];
                        r.sign_b = s[0];
                        r.a      = corners[i];
                        r.b      = corners[j];
                        run_op($sformatf("corner_%0d_%0d_s%0d_w%0d", i, j, s, w),
                               r, model_mul(r));
                    end
                end
            end
        end

        check_timing("timing_held_valid");

        $display("tb_mul: %0d value errors, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

/* verilog.f */
rtl/mul_pkg.sv
rtl/booth_stage.sv
rtl/csa_stage.sv
rtl/mul_top.sv
verif/mul_props.sv
verif/tb_mul.sv

/* Bender.yml */
package:
  name: mul64

sources:
  # design
  - rtl/mul_pkg.sv
  - rtl/booth_stage.sv
  - rtl/csa_stage.sv
  - rtl/mul_top.sv

  # verification
  - target: simulation
    files:
      - verif/mul_props.sv
      - verif/tb_mul.sv
